// File: common/bp_pkg.sv
package bp_pkg;

    typedef logic [31:0] addr_t;

    localparam int RAS_SIZE = 16; // Default stack depth

    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // J-type view, immediate still in its scrambled order
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } jal_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } jalr_fmt_t;

    typedef union packed {
        jal_fmt_t  j;
        jalr_fmt_t i;
    } inst_u;

    typedef enum logic [2:0] {
        NONE,
        CALL,
        RET,
        JUMP,
        INDIRECT
    } br_kind_e;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_u inst;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        br_kind_e    kind;
        logic        reg_tgt; // Target comes from a register (JALR)
        addr_t       pc;
        logic [31:0] imm;     // Sign extended
    } decode_t;

    typedef struct packed {
        logic     valid;
        br_kind_e kind;
        addr_t    target;
        logic     target_ok;
        logic     ras_fail;
    } pred_t;

endpackage

// File: ras/ras_store.sv
`timescale 1ns/1ps

module ras_store #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  bp_pkg::addr_t            wdata,
    output bp_pkg::addr_t            rdata
);
    import bp_pkg::*;

    addr_t entries [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            entries[addr] <= wdata;
        end
    end

    assign rdata = entries[addr]; // Read is combinational

endmodule

// File: ras/ras.sv
`timescale 1ns/1ps

module ras #(
    parameter int RAS_SIZE = bp_pkg::RAS_SIZE
) (
    input  logic          clk,
    input  logic          resetn,
    input  logic          push,
    input  logic          pop,
    input  bp_pkg::addr_t ret_pc_push,
    output bp_pkg::addr_t ret_pc_pop,
    output logic          fail
);
    import bp_pkg::*;

    localparam int PTR_W = $clog2(RAS_SIZE);

    // top stays 0 for both zero and one entries, empty tells them apart
    logic [PTR_W-1:0]    top;
    logic [PTR_W-1:0]    top_nxt;
    logic [PTR_W-1:0]    ras_addr;
    logic                empty;
    logic                empty_nxt;
    logic                overflow;
    logic                overflow_nxt;
    logic                full;
    logic [RAS_SIZE-1:0] overflow_counter;
    logic [RAS_SIZE-1:0] overflow_counter_nxt;
    addr_t               w_ret_pc;
    addr_t               r_ret_pc;

    assign full       = &top;
    assign fail       = empty || overflow;
    assign ret_pc_pop = r_ret_pc;

    always_comb begin
        empty_nxt = empty;
        if (push) begin
            empty_nxt = 1'b0;
        end else if (pop && top == '0) begin
            empty_nxt = 1'b1;
        end
    end

    always_comb begin
        top_nxt = top;
        if (push && !full && !empty) begin
            top_nxt = top + 1'b1;
        end else if (pop && (|top) && !overflow) begin
            top_nxt = top - 1'b1;
        end
    end

    always_comb begin
        overflow_counter_nxt = overflow_counter;
        if (push && full) begin
            overflow_counter_nxt = overflow_counter + 1'b1; // Dropped push
        end else if (pop && (|overflow_counter)) begin
            overflow_counter_nxt = overflow_counter - 1'b1;
        end
    end

    // Tracks the counter so back-to-back pops see it clear at once
    assign overflow_nxt = |overflow_counter_nxt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            top              <= '0;
            empty            <= 1'b1;
            overflow         <= 1'b0;
            overflow_counter <= '0;
        end else begin
            top              <= top_nxt;
            empty            <= empty_nxt;
            overflow         <= overflow_nxt;
            overflow_counter <= overflow_counter_nxt;
        end
    end

    assign ras_addr = push ? top_nxt : top;
    assign w_ret_pc = full ? r_ret_pc : ret_pc_push; // Full push keeps the old entry

    ras_store #(
        .DEPTH(RAS_SIZE)
    ) u_store (
        .clk  (clk),
        .we   (push),
        .addr (ras_addr),
        .wdata(w_ret_pc),
        .rdata(r_ret_pc)
    );

endmodule

// File: source/bp_predecode.sv
`timescale 1ns/1ps

module bp_predecode (
    input  bp_pkg::fetch_req_t fetch,
    output bp_pkg::decode_t    dec
);
    import bp_pkg::*;

    inst_u       word;
    logic        is_jal;
    logic        is_jalr;
    logic        rd_link;
    logic        rs1_link;
    logic [31:0] j_imm;
    logic [31:0] i_imm;
    br_kind_e    kind;

    assign word = fetch.inst;

    // Opcode and rd sit at the same bits in both views
    assign is_jal  = (word.j.opcode == OPC_JAL);
    assign is_jalr = (word.i.opcode == OPC_JALR);

    assign rd_link  = (word.j.rd == 5'd1) || (word.j.rd == 5'd5);
    assign rs1_link = (word.i.rs1 == 5'd1) || (word.i.rs1 == 5'd5);

    // imm[20|10:1|11|19:12]
    assign j_imm = {{11{word.j.imm[19]}}, word.j.imm[19], word.j.imm[7:0],
                    word.j.imm[8], word.j.imm[18:9], 1'b0};
    assign i_imm = {{20{word.i.imm[11]}}, word.i.imm};

    always_comb begin
        kind = NONE;
        if (fetch.valid) begin
            if (is_jal) begin
                kind = rd_link ? CALL : JUMP;
            end else if (is_jalr) begin
                if (rd_link) begin
                    kind = CALL; // Coroutine form also lands here
                end else if (word.i.rd == 5'd0 && rs1_link) begin
                    kind = RET;
                end else begin
                    kind = INDIRECT;
                end
            end
        end
    end

    always_comb begin
        dec.valid   = fetch.valid;
        dec.kind    = kind;
        dec.reg_tgt = is_jalr;
        dec.pc      = fetch.pc;
        dec.imm     = is_jal ? j_imm : i_imm;
    end

endmodule

// File: source/bp_target.sv
`timescale 1ns/1ps

module bp_target (
    input  logic            clk,
    input  logic            resetn,
    input  bp_pkg::decode_t dec,
    output bp_pkg::pred_t   next_pred
);
    import bp_pkg::*;

    logic  push;
    logic  pop;
    logic  fail;
    addr_t ret_pc_push;
    addr_t ret_pc_pop;
    addr_t pc_rel;

    assign push        = dec.valid && (dec.kind == CALL);
    assign pop         = dec.valid && (dec.kind == RET);
    assign ret_pc_push = dec.pc + 32'd4;
    assign pc_rel      = dec.pc + dec.imm;

    ras #(
        .RAS_SIZE(RAS_SIZE)
    ) u_ras (
        .clk        (clk),
        .resetn     (resetn),
        .push       (push),
        .pop        (pop),
        .ret_pc_push(ret_pc_push),
        .ret_pc_pop (ret_pc_pop),
        .fail       (fail)
    );

    always_comb begin
        next_pred.valid     = dec.valid;
        next_pred.kind      = dec.kind;
        next_pred.target    = '0;
        next_pred.target_ok = 1'b0;
        next_pred.ras_fail  = 1'b0;
        case (dec.kind)
            CALL, JUMP: begin
                if (!dec.reg_tgt) begin // JALR target unknown here
                    next_pred.target    = pc_rel;
                    next_pred.target_ok = 1'b1;
                end
            end
            RET: begin
                next_pred.target    = ret_pc_pop;
                next_pred.target_ok = !fail;
                next_pred.ras_fail  = fail; // Seen before the pop
            end
            default: ;
        endcase
    end

endmodule

// File: source/bp_result.sv
`timescale 1ns/1ps

module bp_result (
    input  logic          clk,
    input  logic          resetn,
    input  bp_pkg::pred_t next_pred,
    output bp_pkg::pred_t pred
);
    import bp_pkg::*;

    logic     valid_q;
    br_kind_e kind_q;
    addr_t    target_q;
    logic     target_ok_q;
    logic     ras_fail_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= next_pred.valid; // One cycle strobe
        end
    end

    // Payload holds between strobes
    always_ff @(posedge clk) begin
        if (next_pred.valid) begin
            kind_q      <= next_pred.kind;
            target_q    <= next_pred.target;
            target_ok_q <= next_pred.target_ok;
            ras_fail_q  <= next_pred.ras_fail;
        end
    end

    always_comb begin
        pred.valid     = valid_q;
        pred.kind      = kind_q;
        pred.target    = target_q;
        pred.target_ok = target_ok_q;
        pred.ras_fail  = ras_fail_q;
    end

endmodule

// File: source/bp_top.sv
`timescale 1ns/1ps

module bp_top (
    input  logic               clk,
    input  logic               resetn,
    input  bp_pkg::fetch_req_t fetch,
    output bp_pkg::pred_t      pred
);
    import bp_pkg::*;

    decode_t dec;
    pred_t   next_pred;

    bp_predecode u_predecode (
        .fetch(fetch),
        .dec  (dec)
    );

    bp_target u_target (
        .clk      (clk),
        .resetn   (resetn),
        .dec      (dec),
        .next_pred(next_pred)
    );

    bp_result u_result (
        .clk      (clk),
        .resetn   (resetn),
        .next_pred(next_pred),
        .pred     (pred)
    );

endmodule

// File: tb/bp_checker.sv
`timescale 1ns/1ps

module bp_checker #(
    parameter int RAS_SIZE = bp_pkg::RAS_SIZE
) (
    input logic                        clk,
    input logic                        resetn,
    input logic                        push,
    input logic                        pop,
    input logic                        empty,
    input logic                        overflow,
    input logic [$clog2(RAS_SIZE)-1:0] top
);

    a_push_pop_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(push && pop))
        else $error("RAS push and pop asserted in the same cycle");

    a_top_hold: assert property (@(posedge clk) disable iff (!resetn)
        (!push && !pop) |=> $stable(top))
        else $error("RAS top moved without a push or pop");

    // Plain pop above the bottom entry
    a_pop_dec: assert property (@(posedge clk) disable iff (!resetn)
        (pop && !empty && !overflow && top != '0) |=> (top == $past(top) - 1'b1))
        else $error("RAS pop did not decrement top by one");

endmodule

bind ras bp_checker #(
    .RAS_SIZE(RAS_SIZE)
) u_checker (
    .clk     (clk),
    .resetn  (resetn),
    .push    (push),
    .pop     (pop),
    .empty   (empty),
    .overflow(overflow),
    .top     (top)
);

// File: tb/bp_tb.sv
`timescale 1ns/1ps

module bp_tb;
    import bp_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_STROBES  = 74; // All tests together
    localparam int CYCLE_LIMIT  = 20 * NUM_STROBES + RESET_CYCLES;

    logic       clk;
    logic       resetn;
    fetch_req_t fetch;
    pred_t      pred;
    pred_t      exp;
    logic       pending;
    int         errors;
    int         cycles = 0;
    addr_t      ras_q[$]; // Reference stack, top at the back
    int         ovf_cnt;

    bp_top u_dut (
        .clk   (clk),
        .resetn(resetn),
        .fetch (fetch),
        .pred  (pred)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no end of test after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_kind(input string name, input br_kind_e got, input br_kind_e want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic model_push(input addr_t ret_pc);
        if (ras_q.size() < RAS_SIZE)
            ras_q.push_back(ret_pc);
        else
            ovf_cnt++; // Dropped but remembered
    endtask

    task automatic model_pop(output addr_t tgt, output logic failed);
        failed = (ovf_cnt > 0) || (ras_q.size() == 0);
        tgt    = '0;
        if (ovf_cnt > 0)
            ovf_cnt--;
        else if (ras_q.size() > 0)
            tgt = ras_q.pop_back();
    endtask

    // Checks the previous strobe's prediction, then drives the next fetch
    task automatic tick(input logic vld, input addr_t pc, input logic [31:0] inst,
                        input pred_t want);
        @(negedge clk);
        check_flag("pred.valid", pred.valid, pending);
        if (pending && pred.valid) begin
            check_kind("pred.kind", pred.kind, exp.kind);
            check_flag("pred.target_ok", pred.target_ok, exp.target_ok);
            check_flag("pred.ras_fail", pred.ras_fail, exp.ras_fail);
            if (exp.kind != RET || exp.target_ok)
                check_addr("pred.target", pred.target, exp.target);
        end
        fetch.valid = vld;
        fetch.pc    = pc;
        fetch.inst  = inst;
        pending     = vld;
        exp         = want;
    endtask

    function automatic addr_t rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    function automatic logic [20:0] rand_imm(input logic neg);
        logic [20:0] r;
        r     = 21'($urandom);
        r[20] = neg;
        r[0]  = 1'b0;
        return r;
    endfunction

    task automatic send_idle();
        tick(1'b0, '0, '0, '0);
    endtask

    task automatic send_jal(input addr_t pc, input logic [4:0] rd, input logic [20:0] imm);
        pred_t       want;
        logic [31:0] inst;
        inst           = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
        want           = '0;
        want.valid     = 1'b1;
        want.kind      = (rd == 5'd1 || rd == 5'd5) ? CALL : JUMP;
        want.target    = pc + {{11{imm[20]}}, imm};
        want.target_ok = 1'b1;
        if (want.kind == CALL)
            model_push(pc + 32'd4);
        tick(1'b1, pc, inst, want);
    endtask

    task automatic send_jalr(input addr_t pc, input logic [4:0] rd, input logic [4:0] rs1);
        pred_t       want;
        logic [11:0] imm;
        imm        = 12'($urandom);
        want       = '0;
        want.valid = 1'b1;
        if (rd == 5'd1 || rd == 5'd5) begin
            want.kind = CALL;
            model_push(pc + 32'd4);
        end else if (rd == 5'd0 && (rs1 == 5'd1 || rs1 == 5'd5)) begin
            want.kind = RET;
            model_pop(want.target, want.ras_fail);
            want.target_ok = !want.ras_fail;
        end else begin
            want.kind = INDIRECT;
        end
        tick(1'b1, pc, {imm, rs1, 3'b000, rd, OPC_JALR}, want);
    endtask

    task automatic test_reset_ret();
        repeat (3)
            send_idle();
        send_jalr(rand_pc(), 5'd0, 5'd1); // Empty stack
        send_idle();
    endtask

    task automatic test_jal_targets();
        for (int i = 0; i < 4; i++) begin
            send_jal(rand_pc(), 5'd0, rand_imm(i[0]));
            send_jal(rand_pc(), (i < 2) ? 5'd1 : 5'd5, rand_imm(!i[0]));
        end
        repeat (4)
            send_jalr(rand_pc(), 5'd0, 5'd5);
        send_idle();
    endtask

    task automatic test_nested(input int depth);
        repeat (depth)
            send_jal(rand_pc(), 5'd1, rand_imm(1'b0));
        repeat (depth)
            send_jalr(rand_pc(), 5'd0, 5'd1);
        send_idle();
    endtask

    task automatic test_jalr_kinds();
        send_jalr(rand_pc(), 5'd2, 5'd6);
        send_jalr(rand_pc(), 5'd1, 5'd6);
        send_jalr(rand_pc(), 5'd0, 5'd5);
        send_idle();
    endtask

    task automatic test_back_to_back();
        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 0)
                send_jal(rand_pc(), 5'd5, rand_imm(i[0]));
            else if (i % 3 == 1)
                send_jalr(rand_pc(), 5'd1, 5'd7);
            else
                send_jalr(rand_pc(), 5'd0, 5'd1);
        end
        send_idle();
    endtask

    initial begin
        void'($urandom(34204));
        clk     = 1'b0;
        resetn  = 1'b0;
        fetch   = '0;
        pending = 1'b0;
        exp     = '0;
        errors  = 0;
        ovf_cnt = 0;
        repeat (RESET_CYCLES)
            @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        test_reset_ret();
        test_jal_targets();
        test_nested(5);
        test_nested(RAS_SIZE + 2); // Two pushes past full
        test_jalr_kinds();
        test_back_to_back();
        send_idle();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: bp_top.f
common/bp_pkg.sv
ras/ras_store.sv
ras/ras.sv
source/bp_predecode.sv
source/bp_target.sv
source/bp_result.sv
source/bp_top.sv
tb/bp_checker.sv
tb/bp_tb.sv
